// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_ai_cu
FILELIST  = verilog.f
PASS_MSG  = Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== ai_cu_csr.sv ====
module ai_cu_csr #(
    parameter int ADDR_W = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_en,
    input  logic                                rd_en,
    input  logic [ai_cu_pkg::CU_CSR_ADDR_W-1:0] addr,
    input  logic [ai_cu_pkg::CU_DATA_W-1:0]     wdata,
    input  logic                                layer_done,
    input  logic                                busy,
    output logic [ai_cu_pkg::CU_DATA_W-1:0]     rdata,
    cu_csr_if.csr                               csr,
    output logic [ai_cu_pkg::CU_LEN_W-1:0]      seq_len
);

    ai_cu_pkg::csr_word_u wword;

    logic [ADDR_W-1:0]              ifm_base_q;
    logic [ADDR_W-1:0]              ofm_base_q;
    logic [ai_cu_pkg::CU_LEN_W-1:0] ifm_len_q;
    logic [ai_cu_pkg::CU_LEN_W-1:0] ofm_len_q;
    logic [ai_cu_pkg::CU_LEN_W-1:0] seq_len_q;
    logic [7:0]                     layer_cnt;
    logic                           start_q;

    assign wword = wdata;

    ////////////////////////////////////////////////////////////
    // host writes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifm_base_q <= '0;
            ofm_base_q <= '0;
            ifm_len_q  <= '0;
            ofm_len_q  <= '0;
            seq_len_q  <= '0;
            start_q    <= 1'b0;
        end else begin
            // start fires even while busy and the FSM drops it
            start_q <= wr_en && (addr == ai_cu_pkg::CSR_CTRL) && wword.cmd.start;
            if (wr_en) begin
                case (addr)
                    ai_cu_pkg::CSR_IFM_BASE: ifm_base_q <= ADDR_W'(wdata);
                    ai_cu_pkg::CSR_OFM_BASE: ofm_base_q <= ADDR_W'(wdata);
                    ai_cu_pkg::CSR_LENS: begin
                        ifm_len_q <= wword.lens.ifm_len;
                        ofm_len_q <= wword.lens.ofm_len;
                    end
                    ai_cu_pkg::CSR_SEQ_LEN: seq_len_q <= wdata[ai_cu_pkg::CU_LEN_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // completed layers with clear winning over a done in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_cnt <= '0;
        end else if (wr_en && (addr == ai_cu_pkg::CSR_CTRL) && wword.cmd.clear_count) begin
            layer_cnt <= '0;
        end else if (layer_done) begin
            layer_cnt <= layer_cnt + 8'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered read-back
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (rd_en) begin
            case (addr)
                ai_cu_pkg::CSR_IFM_BASE: rdata <= ai_cu_pkg::CU_DATA_W'(ifm_base_q);
                ai_cu_pkg::CSR_OFM_BASE: rdata <= ai_cu_pkg::CU_DATA_W'(ofm_base_q);
                ai_cu_pkg::CSR_LENS:     rdata <= {ofm_len_q, ifm_len_q};
                ai_cu_pkg::CSR_SEQ_LEN:  rdata <= ai_cu_pkg::CU_DATA_W'(seq_len_q);
                ai_cu_pkg::CSR_STATUS:   rdata <= {16'd0, layer_cnt, 7'd0, busy};
                // CTRL bits are write only
                default:                 rdata <= '0;
            endcase
        end
    end

    assign csr.ifm_base      = ifm_base_q;
    assign csr.ofm_base      = ofm_base_q;
    assign csr.ifm_len       = ifm_len_q;
    assign csr.ofm_len       = ofm_len_q;
    assign csr.start_decoded = start_q;
    assign seq_len           = seq_len_q;

endmodule

// ==== ai_cu_fsm.sv ====
module ai_cu_fsm #(
    parameter int ADDR_W = 32
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  seq_done,
    cu_csr_if.fsm csr,
    cu_mem_if.fsm mem,
    output logic  seq_start,
    output logic  phase_fetch,
    output logic  phase_compute,
    output logic  phase_writeback,
    output logic  layer_done,
    output logic  busy
);

    ai_cu_pkg::cu_state_t state;
    ai_cu_pkg::cu_state_t n_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ai_cu_pkg::IDLE;
        end else begin
            state <= n_state;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////////////////////////
    always_comb begin
        n_state         = state;
        mem.read_req    = 1'b0;
        mem.read_addr   = {ADDR_W{1'b0}};
        mem.read_len    = '0;
        mem.write_req   = 1'b0;
        mem.write_addr  = {ADDR_W{1'b0}};
        mem.write_len   = '0;
        seq_start       = 1'b0;
        phase_fetch     = 1'b0;
        phase_compute   = 1'b0;
        phase_writeback = 1'b0;
        layer_done      = 1'b0;

        case (state)
            ai_cu_pkg::IDLE: begin
                if (csr.start_decoded) begin
                    n_state = ai_cu_pkg::FETCH_IFM;
                end
            end
            ai_cu_pkg::FETCH_IFM: begin
                phase_fetch   = 1'b1;
                mem.read_req  = 1'b1;
                mem.read_addr = csr.ifm_base;
                mem.read_len  = csr.ifm_len;
                if (mem.read_done) begin
                    n_state = ai_cu_pkg::START_SEQ;
                end
            end
            // single cycle kick to the sequencer
            ai_cu_pkg::START_SEQ: begin
                seq_start = 1'b1;
                n_state   = ai_cu_pkg::WAIT_SEQ;
            end
            ai_cu_pkg::WAIT_SEQ: begin
                phase_compute = 1'b1;
                if (seq_done) begin
                    n_state = ai_cu_pkg::WRITEBACK;
                end
            end
            ai_cu_pkg::WRITEBACK: begin
                phase_writeback = 1'b1;
                mem.write_req   = 1'b1;
                mem.write_addr  = csr.ofm_base;
                mem.write_len   = csr.ofm_len;
                if (mem.write_done) begin
                    n_state = ai_cu_pkg::DONE;
                end
            end
            ai_cu_pkg::DONE: begin
                layer_done = 1'b1;
                n_state    = ai_cu_pkg::IDLE;
            end
            default: n_state = ai_cu_pkg::IDLE;
        endcase
    end

    // a start seen outside IDLE is dropped
    assign busy = (state != ai_cu_pkg::IDLE);

endmodule

// ==== ai_cu_if.sv ====
////////////////////////////////////////////////////////////
// CSR block to layer FSM
////////////////////////////////////////////////////////////
interface cu_csr_if #(
    parameter int ADDR_W = 32
);
    logic [ADDR_W-1:0]             ifm_base;
    logic [ADDR_W-1:0]             ofm_base;
    logic [ai_cu_pkg::CU_LEN_W-1:0] ifm_len;
    logic [ai_cu_pkg::CU_LEN_W-1:0] ofm_len;
    // one cycle wide
    logic                          start_decoded;

    modport csr (output ifm_base, ofm_base, ifm_len, ofm_len, start_decoded);
    modport fsm (input ifm_base, ofm_base, ifm_len, ofm_len, start_decoded);
endinterface

////////////////////////////////////////////////////////////
// layer FSM to memory transfer engine
////////////////////////////////////////////////////////////
interface cu_mem_if #(
    parameter int ADDR_W = 32
);
    // requests are levels held for the whole FSM state
    logic                          read_req;
    logic [ADDR_W-1:0]             read_addr;
    logic [ai_cu_pkg::CU_LEN_W-1:0] read_len;
    logic                          write_req;
    logic [ADDR_W-1:0]             write_addr;
    logic [ai_cu_pkg::CU_LEN_W-1:0] write_len;
    // single cycle completions
    logic                          read_done;
    logic                          write_done;

    modport fsm (
        output read_req, read_addr, read_len, write_req, write_addr, write_len,
        input  read_done, write_done
    );
    modport engine (
        input  read_req, read_addr, read_len, write_req, write_addr, write_len,
        output read_done, write_done
    );
endinterface

// ==== ai_cu_pkg.sv ====
package ai_cu_pkg;

    // widths shared by the CSR block, FSM and sequencer
    localparam int CU_LEN_W      = 16;
    localparam int CU_DATA_W     = 32;
    localparam int CU_CSR_ADDR_W = 3;

    ////////////////////////////////////////////////////////////
    // CSR map
    ////////////////////////////////////////////////////////////
    localparam logic [CU_CSR_ADDR_W-1:0] CSR_CTRL     = 3'd0;
    localparam logic [CU_CSR_ADDR_W-1:0] CSR_IFM_BASE = 3'd1;
    localparam logic [CU_CSR_ADDR_W-1:0] CSR_OFM_BASE = 3'd2;
    localparam logic [CU_CSR_ADDR_W-1:0] CSR_LENS     = 3'd3;
    localparam logic [CU_CSR_ADDR_W-1:0] CSR_SEQ_LEN  = 3'd4;
    localparam logic [CU_CSR_ADDR_W-1:0] CSR_STATUS   = 3'd5;

    // layer flow
    typedef enum logic [2:0] {
        IDLE,
        FETCH_IFM,
        START_SEQ,
        WAIT_SEQ,
        WRITEBACK,
        DONE
    } cu_state_t;

    // one host word, seen as a command (CTRL) or as two lengths (LENS)
    typedef union packed {
        struct packed {
            logic [29:0] rsvd;
            logic        clear_count;
            logic        start;
        } cmd;
        struct packed {
            logic [CU_LEN_W-1:0] ofm_len;
            logic [CU_LEN_W-1:0] ifm_len;
        } lens;
    } csr_word_u;

endpackage

// ==== ai_cu_properties.sv ====
module ai_cu_properties (
    input logic                 clk,
    input logic                 rst,
    input ai_cu_pkg::cu_state_t state,
    input logic                 read_req,
    input logic                 write_req,
    input logic                 read_done,
    input logic                 write_done,
    input logic                 seq_start
);
    timeunit 1ns;
    timeprecision 1ps;

    // the FSM never asks for both directions at once
    req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(read_req && write_req))
        else $error("read and write requests high together");

    read_done_pulse: assert property (@(posedge clk) disable iff (rst)
        read_done |=> !read_done)
        else $error("read_done high two cycles in a row");

    write_done_pulse: assert property (@(posedge clk) disable iff (rst)
        write_done |=> !write_done)
        else $error("write_done high two cycles in a row");

    // kick only from START_SEQ and one cycle wide
    seq_start_pulse: assert property (@(posedge clk) disable iff (rst)
        seq_start |-> (state == ai_cu_pkg::START_SEQ) ##1 !seq_start)
        else $error("seq_start longer than one cycle or outside START_SEQ");

endmodule

bind ai_cu_fsm ai_cu_properties props_i (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .read_req   (mem.read_req),
    .write_req  (mem.write_req),
    .read_done  (mem.read_done),
    .write_done (mem.write_done),
    .seq_start  (seq_start)
);

// ==== ai_cu_seq.sv ====
module ai_cu_seq (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           seq_start,
    input  logic [ai_cu_pkg::CU_LEN_W-1:0] seq_len,
    output logic                           seq_done,
    output logic                           seq_active
);

    logic                           running;
    logic [ai_cu_pkg::CU_LEN_W-1:0] steps_left;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running    <= 1'b0;
            steps_left <= '0;
        end else if (seq_start) begin
            running    <= 1'b1;
            steps_left <= seq_len;
        end else if (running) begin
            if (seq_done) begin
                running <= 1'b0;
            end
            if (steps_left != '0) begin
                steps_left <= steps_left - ai_cu_pkg::CU_LEN_W'(1);
            end
        end
    end

    // zero steps still gives a done one cycle after start
    assign seq_done   = running && (steps_left <= ai_cu_pkg::CU_LEN_W'(1));
    assign seq_active = running && (steps_left != '0);

endmodule

// ==== ai_cu_top.sv ====
module ai_cu_top #(
    parameter int ADDR_W = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_en,
    input  logic                                rd_en,
    input  logic [ai_cu_pkg::CU_CSR_ADDR_W-1:0] addr,
    input  logic [ai_cu_pkg::CU_DATA_W-1:0]     wdata,
    output logic [ai_cu_pkg::CU_DATA_W-1:0]     rdata,
    output logic                                mem_beat_valid,
    output logic                                mem_beat_we,
    output logic [ADDR_W-1:0]                   mem_beat_addr,
    output logic                                phase_fetch,
    output logic                                phase_compute,
    output logic                                phase_writeback,
    output logic                                seq_active,
    output logic                                layer_done
);

    logic                           seq_start;
    logic                           seq_done;
    logic                           busy;
    logic [ai_cu_pkg::CU_LEN_W-1:0] seq_len;

    cu_csr_if #(.ADDR_W(ADDR_W)) csr_if ();
    cu_mem_if #(.ADDR_W(ADDR_W)) mem_if ();

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////
    ai_cu_csr #(.ADDR_W(ADDR_W)) csr_i (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .addr       (addr),
        .wdata      (wdata),
        .layer_done (layer_done),
        .busy       (busy),
        .rdata      (rdata),
        .csr        (csr_if.csr),
        .seq_len    (seq_len)
    );

    ////////////////////////////////////////////////////////////
    // layer control, memory engine and sequencer
    ////////////////////////////////////////////////////////////
    ai_cu_fsm #(.ADDR_W(ADDR_W)) fsm_i (
        .clk             (clk),
        .rst             (rst),
        .seq_done        (seq_done),
        .csr             (csr_if.fsm),
        .mem             (mem_if.fsm),
        .seq_start       (seq_start),
        .phase_fetch     (phase_fetch),
        .phase_compute   (phase_compute),
        .phase_writeback (phase_writeback),
        .layer_done      (layer_done),
        .busy            (busy)
    );

    ai_mem_xfer #(.ADDR_W(ADDR_W)) mem_xfer_i (
        .clk        (clk),
        .rst        (rst),
        .mem        (mem_if.engine),
        .beat_valid (mem_beat_valid),
        .beat_we    (mem_beat_we),
        .beat_addr  (mem_beat_addr)
    );

    ai_cu_seq seq_i (
        .clk        (clk),
        .rst        (rst),
        .seq_start  (seq_start),
        .seq_len    (seq_len),
        .seq_done   (seq_done),
        .seq_active (seq_active)
    );

endmodule

// ==== ai_mem_xfer.sv ====
module ai_mem_xfer #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    cu_mem_if.engine          mem,
    output logic              beat_valid,
    output logic              beat_we,
    output logic [ADDR_W-1:0] beat_addr
);

    logic                           active;
    logic                           gap;
    logic                           accept;
    logic                           last;
    logic [ai_cu_pkg::CU_LEN_W-1:0] remain;
    logic [ADDR_W-1:0]              cur_addr;
    logic                           dir_we;

    // requests are looked at only when neither busy nor cooling down
    assign accept = !active && !gap && (mem.read_req || mem.write_req);
    // zero length finishes in its first cycle
    assign last   = active && (remain <= ai_cu_pkg::CU_LEN_W'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            gap    <= 1'b0;
        end else begin
            gap <= 1'b0;
            if (accept) begin
                active <= 1'b1;
            end else if (last) begin
                active <= 1'b0;
                gap    <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // transfer descriptor where read wins if both ask
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            dir_we   <= !mem.read_req;
            cur_addr <= mem.read_req ? mem.read_addr : mem.write_addr;
            remain   <= mem.read_req ? mem.read_len : mem.write_len;
        end else if (active && (remain != '0)) begin
            cur_addr <= cur_addr + ADDR_W'(1);
            remain   <= remain - ai_cu_pkg::CU_LEN_W'(1);
        end
    end

    assign beat_valid     = active && (remain != '0);
    assign beat_we        = dir_we;
    assign beat_addr      = cur_addr;
    assign mem.read_done  = last && !dir_we;
    assign mem.write_done = last && dir_we;

endmodule

// ==== tb_ai_cu.sv ====
module tb_ai_cu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst;
    logic        wr_en;
    logic        rd_en;
    logic [2:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        mem_beat_valid;
    logic        mem_beat_we;
    logic [31:0] mem_beat_addr;
    logic        phase_fetch;
    logic        phase_compute;
    logic        phase_writeback;
    logic        seq_active;
    logic        layer_done;

    int          errors;
    int          cycles;
    integer      seed;
    logic [31:0] rd_q[$];
    logic [31:0] wr_q[$];
    int          seq_cycles;
    int          done_cnt;
    int          stage;
    // expected layer settings for the checks in finish_layer
    logic [31:0] exp_ib;
    logic [31:0] exp_ob;
    logic [31:0] exp_il;
    logic [31:0] exp_ol;
    logic [31:0] exp_sl;

    ai_cu_top #(.ADDR_W(32)) ai_cu_top_i (
        .clk             (clk),
        .rst             (rst),
        .wr_en           (wr_en),
        .rd_en           (rd_en),
        .addr            (addr),
        .wdata           (wdata),
        .rdata           (rdata),
        .mem_beat_valid  (mem_beat_valid),
        .mem_beat_we     (mem_beat_we),
        .mem_beat_addr   (mem_beat_addr),
        .phase_fetch     (phase_fetch),
        .phase_compute   (phase_compute),
        .phase_writeback (phase_writeback),
        .seq_active      (seq_active),
        .layer_done      (layer_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // beat monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_beat_valid && !mem_beat_we) begin
                rd_q.push_back(mem_beat_addr);
                check_true(phase_fetch && stage == 0, "read beat outside the fetch phase");
            end
            if (seq_active) begin
                seq_cycles++;
                check_true(phase_compute && stage <= 1, "compute step outside its phase");
                stage = 1;
            end
            if (mem_beat_valid && mem_beat_we) begin
                wr_q.push_back(mem_beat_addr);
                check_true(phase_writeback && stage <= 2,
                           "write beat outside the writeback phase or after layer_done");
                stage = 2;
            end
            if (layer_done) begin
                done_cnt++;
                stage = 3;
            end
        end
    end

    task automatic csr_write(input logic [2:0] a, input logic [31:0] d);
        @(negedge clk);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // rdata is registered, so it is ready one cycle after rd_en
    task automatic csr_read(input logic [2:0] a, output logic [31:0] d);
        @(negedge clk);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en = 1'b0;
        d     = rdata;
    endtask

    task automatic start_layer(input logic [31:0] ib, input logic [31:0] ob,
                               input logic [31:0] il, input logic [31:0] ol,
                               input logic [31:0] sl);
        exp_ib = ib;
        exp_ob = ob;
        exp_il = il;
        exp_ol = ol;
        exp_sl = sl;
        csr_write(ai_cu_pkg::CSR_IFM_BASE, ib);
        csr_write(ai_cu_pkg::CSR_OFM_BASE, ob);
        csr_write(ai_cu_pkg::CSR_LENS, {ol[15:0], il[15:0]});
        csr_write(ai_cu_pkg::CSR_SEQ_LEN, sl);
        rd_q.delete();
        wr_q.delete();
        seq_cycles = 0;
        done_cnt   = 0;
        stage      = 0;
        csr_write(ai_cu_pkg::CSR_CTRL, 32'h1);
    endtask

    task automatic finish_layer();
        while (!layer_done) @(negedge clk);
        // quiet period to catch a stray second layer
        repeat (8) @(negedge clk);
        check_value("read beat count", exp_il, rd_q.size());
        foreach (rd_q[i]) check_value("read mem_beat_addr", exp_ib + i, rd_q[i]);
        check_value("seq_active cycles", exp_sl, seq_cycles);
        check_value("write beat count", exp_ol, wr_q.size());
        foreach (wr_q[i]) check_value("write mem_beat_addr", exp_ob + i, wr_q[i]);
        check_value("layer_done pulses", 1, done_cnt);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        logic [31:0] d;
        check_value("control outputs", 0, {26'd0, mem_beat_valid, phase_fetch, phase_compute,
                    phase_writeback, seq_active, layer_done});
        for (int a = 0; a < 6; a++) begin
            csr_read(3'(a), d);
            check_value($sformatf("rdata csr %0d", a), 0, d);
        end
    endtask

    task automatic test_csr_readback();
        logic [31:0] d;
        csr_write(ai_cu_pkg::CSR_IFM_BASE, 32'h1234_5678);
        csr_write(ai_cu_pkg::CSR_OFM_BASE, 32'h9abc_def0);
        csr_write(ai_cu_pkg::CSR_LENS, 32'h0005_0003);
        csr_write(ai_cu_pkg::CSR_SEQ_LEN, 32'h0000_0007);
        csr_read(ai_cu_pkg::CSR_IFM_BASE, d);
        check_value("rdata ifm_base", 32'h1234_5678, d);
        csr_read(ai_cu_pkg::CSR_OFM_BASE, d);
        check_value("rdata ofm_base", 32'h9abc_def0, d);
        csr_read(ai_cu_pkg::CSR_LENS, d);
        // ofm_len sits in the upper half
        check_value("rdata lens ofm_len", 32'd5, 32'(d[31:16]));
        check_value("rdata lens ifm_len", 32'd3, 32'(d[15:0]));
        csr_read(ai_cu_pkg::CSR_SEQ_LEN, d);
        check_value("rdata seq_len", 32'd7, d);
    endtask

    task automatic test_full_layer();
        start_layer(32'h0000_0100, 32'h0000_0200, 32'd5, 32'd3, 32'd4);
        finish_layer();
    endtask

    task automatic test_layer_count();
        logic [31:0] d;
        logic [31:0] il;
        logic [31:0] ol;
        logic [31:0] sl;
        csr_write(ai_cu_pkg::CSR_CTRL, 32'h2);
        for (int n = 0; n < 3; n++) begin
            il = ($unsigned($random(seed)) % 32'd8) + 32'd1;
            ol = ($unsigned($random(seed)) % 32'd8) + 32'd1;
            sl = ($unsigned($random(seed)) % 32'd8) + 32'd1;
            start_layer(32'h1000 * (n + 1), 32'h8000 + 32'h40 * n, il, ol, sl);
            @(negedge clk);
            csr_read(ai_cu_pkg::CSR_STATUS, d);
            check_value("status busy", 32'd1, 32'(d[0]));
            finish_layer();
        end
        csr_read(ai_cu_pkg::CSR_STATUS, d);
        check_value("status after 3 layers", 32'h0000_0300, d);
        csr_write(ai_cu_pkg::CSR_CTRL, 32'h2);
        csr_read(ai_cu_pkg::CSR_STATUS, d);
        check_value("status after clear", 32'h0, d);
    endtask

    task automatic test_zero_lengths();
        start_layer(32'h0000_0400, 32'h0000_0500, 32'd0, 32'd0, 32'd0);
        finish_layer();
    endtask

    task automatic test_start_while_busy();
        start_layer(32'h0000_0600, 32'h0000_0700, 32'd4, 32'd4, 32'd4);
        repeat (3) @(negedge clk);
        // FSM is mid-fetch here
        csr_write(ai_cu_pkg::CSR_CTRL, 32'h1);
        finish_layer();
    endtask

    initial begin
        rst    = 1'b1;
        wr_en  = 1'b0;
        rd_en  = 1'b0;
        addr   = 3'd0;
        wdata  = 32'd0;
        errors = 0;
        seed   = 32'h88a5;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_csr_readback();
        test_full_layer();
        test_layer_count();
        test_zero_lengths();
        test_start_while_busy();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
ai_cu_pkg.sv
ai_cu_if.sv
ai_cu_csr.sv
ai_cu_fsm.sv
ai_mem_xfer.sv
ai_cu_seq.sv
ai_cu_top.sv
ai_cu_properties.sv
tb_ai_cu.sv
